/* hw/parking_params.svh */
`ifndef PARKING_PARAMS_SVH
`define PARKING_PARAMS_SVH

// cycles the debouncer ignores its input after an accepted edge
`define DB_LOCK_CYCLES 16

// cycles each display digit stays selected
`define REFRESH_CYCLES 8

// highest occupancy the counter will reach
`define LOT_CAPACITY 16'h0123

`endif

/* hw/parking_pkg.sv */
package parking_pkg;

    // occupancy count, shown as four hex digits
    typedef logic [15:0] count_t;

    // one hex digit of the display
    typedef logic [3:0] nibble_t;

    // active low, bit 7 is the decimal point, bits 6..0 are g..a
    typedef logic [7:0] sseg_t;

    // two-sensor pass tracking
    // ENTER_* follow a then b, EXIT_* follow b then a
    typedef enum logic [2:0] {
        IDLE     = 3'd0,
        ENTER_A  = 3'd1,   // a blocked only
        ENTER_AB = 3'd2,   // both blocked, a first
        ENTER_B  = 3'd3,   // b blocked only, a released
        EXIT_B   = 3'd4,   // b blocked only
        EXIT_AB  = 3'd5,   // both blocked, b first
        EXIT_A   = 3'd6    // a blocked only, b released
    } lot_state_e;

endpackage

/* hw/debouncer_early_det.sv */
`timescale 1ns/100ps

`include "parking_params.svh"

module debouncer_early_det (
    input  logic i_clk,
    input  logic i_reset,
    input  logic i_sw,
    output logic o_sw_debounced
);

    localparam int LOCK_W = $clog2(`DB_LOCK_CYCLES + 1);

    logic [LOCK_W-1:0] lock_cnt;
    logic              locked;

    assign locked = (lock_cnt != '0);

    // first edge passes straight through, then bounce is ignored
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_sw_debounced <= 1'b0;
            lock_cnt       <= '0;
        end else if (locked) begin
            lock_cnt <= lock_cnt - 1'b1;   // hold level
        end else if (i_sw != o_sw_debounced) begin
            o_sw_debounced <= i_sw;
            lock_cnt       <= LOCK_W'(`DB_LOCK_CYCLES);
        end
    end

    // output is frozen for the whole lock window
    a_stable_in_lock : assert property (
        @(posedge i_clk) disable iff (i_reset)
        locked |=> $stable(o_sw_debounced)
    );

endmodule

/* hw/parking_lot_occupancy_counter.sv */
`timescale 1ns/100ps

module parking_lot_occupancy_counter (
    input  logic i_clk,
    input  logic i_reset,
    input  logic i_a,
    input  logic i_b,
    output logic o_car_enter,
    output logic o_car_exit
);

    parking_pkg::lot_state_e state;
    parking_pkg::lot_state_e state_next;
    logic                    enter_next;
    logic                    exit_next;
    logic [1:0]              ab;

    assign ab = {i_a, i_b};

    always_comb begin
        state_next = state;
        enter_next = 1'b0;
        exit_next  = 1'b0;
        case (state)
            parking_pkg::IDLE: begin
                case (ab)
                    2'b10:   state_next = parking_pkg::ENTER_A;
                    2'b01:   state_next = parking_pkg::EXIT_B;
                    default: state_next = parking_pkg::IDLE;
                endcase
            end
            parking_pkg::ENTER_A: begin
                case (ab)
                    2'b11:   state_next = parking_pkg::ENTER_AB;
                    2'b10:   state_next = parking_pkg::ENTER_A;
                    default: state_next = parking_pkg::IDLE;
                endcase
            end
            parking_pkg::ENTER_AB: begin
                case (ab)
                    2'b01:   state_next = parking_pkg::ENTER_B;
                    2'b10:   state_next = parking_pkg::ENTER_A;   // backed out
                    2'b11:   state_next = parking_pkg::ENTER_AB;
                    default: state_next = parking_pkg::IDLE;
                endcase
            end
            parking_pkg::ENTER_B: begin
                case (ab)
                    2'b00: begin
                        state_next = parking_pkg::IDLE;
                        enter_next = 1'b1;   // full pass a -> b
                    end
                    2'b11:   state_next = parking_pkg::ENTER_AB;
                    2'b01:   state_next = parking_pkg::ENTER_B;
                    default: state_next = parking_pkg::IDLE;
                endcase
            end
            parking_pkg::EXIT_B: begin
                case (ab)
                    2'b11:   state_next = parking_pkg::EXIT_AB;
                    2'b01:   state_next = parking_pkg::EXIT_B;
                    default: state_next = parking_pkg::IDLE;
                endcase
            end
            parking_pkg::EXIT_AB: begin
                case (ab)
                    2'b10:   state_next = parking_pkg::EXIT_A;
                    2'b01:   state_next = parking_pkg::EXIT_B;   // backed out
                    2'b11:   state_next = parking_pkg::EXIT_AB;
                    default: state_next = parking_pkg::IDLE;
                endcase
            end
            parking_pkg::EXIT_A: begin
                case (ab)
                    2'b00: begin
                        state_next = parking_pkg::IDLE;
                        exit_next  = 1'b1;
                    end
                    2'b11:   state_next = parking_pkg::EXIT_AB;
                    2'b10:   state_next = parking_pkg::EXIT_A;
                    default: state_next = parking_pkg::IDLE;
                endcase
            end
            default: state_next = parking_pkg::IDLE;
        endcase
    end

    // pulses registered with the state so they line up with IDLE
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state       <= parking_pkg::IDLE;
            o_car_enter <= 1'b0;
            o_car_exit  <= 1'b0;
        end else begin
            state       <= state_next;
            o_car_enter <= enter_next;
            o_car_exit  <= exit_next;
        end
    end

    a_pulse_excl : assert property (
        @(posedge i_clk) disable iff (i_reset)
        !(o_car_enter && o_car_exit)
    );

    a_enter_one_cycle : assert property (
        @(posedge i_clk) disable iff (i_reset)
        o_car_enter |=> !o_car_enter
    );

    a_exit_one_cycle : assert property (
        @(posedge i_clk) disable iff (i_reset)
        o_car_exit |=> !o_car_exit
    );

endmodule

/* hw/countreg.sv */
`timescale 1ns/100ps

`include "parking_params.svh"

module countreg (
    input  logic                i_clk,
    input  logic                i_reset,
    input  logic                i_inc,
    input  logic                i_dec,
    output parking_pkg::count_t o_count
);

    logic at_max;
    logic at_zero;

    assign at_max  = (o_count == `LOT_CAPACITY);
    assign at_zero = (o_count == '0);

    // saturates at both ends, simultaneous inc and dec cancel
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_count <= '0;
        end else if (i_inc && !i_dec && !at_max) begin
            o_count <= o_count + 1'b1;
        end else if (i_dec && !i_inc && !at_zero) begin
            o_count <= o_count - 1'b1;
        end
    end

    a_within_capacity : assert property (
        @(posedge i_clk) disable iff (i_reset)
        o_count <= `LOT_CAPACITY
    );

endmodule

/* hw/hex_to_sseg.sv */
`timescale 1ns/100ps

module hex_to_sseg (
    input  parking_pkg::nibble_t i_hex,
    input  logic                 i_dp,
    output parking_pkg::sseg_t   o_sseg_n
);

    // segments g..a, low means lit
    always_comb begin
        case (i_hex)
            4'h0:    o_sseg_n[6:0] = 7'b1000000;
            4'h1:    o_sseg_n[6:0] = 7'b1111001;
            4'h2:    o_sseg_n[6:0] = 7'b0100100;
            4'h3:    o_sseg_n[6:0] = 7'b0110000;
            4'h4:    o_sseg_n[6:0] = 7'b0011001;
            4'h5:    o_sseg_n[6:0] = 7'b0010010;
            4'h6:    o_sseg_n[6:0] = 7'b0000010;
            4'h7:    o_sseg_n[6:0] = 7'b1111000;
            4'h8:    o_sseg_n[6:0] = 7'b0000000;
            4'h9:    o_sseg_n[6:0] = 7'b0010000;
            4'ha:    o_sseg_n[6:0] = 7'b0001000;
            4'hb:    o_sseg_n[6:0] = 7'b0000011;   // lower case b
            4'hc:    o_sseg_n[6:0] = 7'b1000110;
            4'hd:    o_sseg_n[6:0] = 7'b0100001;   // lower case d
            4'he:    o_sseg_n[6:0] = 7'b0000110;
            default: o_sseg_n[6:0] = 7'b0001110;   // F
        endcase
        o_sseg_n[7] = ~i_dp;
    end

endmodule

/* hw/led_4_1_mux.sv */
`timescale 1ns/100ps

`include "parking_params.svh"

module led_4_1_mux (
    input  logic               i_clk,
    input  logic               i_reset,
    input  parking_pkg::sseg_t i_in_n [3:0],
    output logic [3:0]         o_ldsel,
    output parking_pkg::sseg_t o_sseg_n
);

    localparam int REF_W = $clog2(`REFRESH_CYCLES + 1);

    logic [REF_W-1:0] refresh_cnt;
    logic [1:0]       digit_idx;
    logic             scan_on;   // blank until the first refresh edge
    logic             refresh_tick;

    assign refresh_tick = (refresh_cnt == REF_W'(`REFRESH_CYCLES - 1));

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            refresh_cnt <= '0;
            digit_idx   <= 2'd0;
            scan_on     <= 1'b0;
        end else if (refresh_tick) begin
            refresh_cnt <= '0;
            digit_idx   <= digit_idx + 1'b1;   // wraps 3 -> 0
            scan_on     <= 1'b1;
        end else begin
            refresh_cnt <= refresh_cnt + 1'b1;
        end
    end

    // select and pattern come from the same index on the same edge
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_ldsel  <= 4'b1110;
            o_sseg_n <= '1;
        end else begin
            o_ldsel  <= ~(4'b0001 << digit_idx);
            o_sseg_n <= scan_on ? i_in_n[digit_idx] : '1;
        end
    end

    a_one_digit : assert property (
        @(posedge i_clk) disable iff (i_reset)
        $onehot(~o_ldsel)
    );

endmodule

/* hw/parking_top.sv */
`timescale 1ns/100ps

module parking_top (
    input  logic                i_clk,
    input  logic                i_reset,
    input  logic [1:0]          i_sw,
    output parking_pkg::count_t o_occupancy_count,
    output parking_pkg::sseg_t  o_sseg_n,
    output logic [3:0]          o_ldsel
);

    logic [1:0]         w_sw_db;
    logic               w_car_enter;
    logic               w_car_exit;
    parking_pkg::sseg_t w_map_n [3:0];

    // sw[0] is sensor a, sw[1] is sensor b
    debouncer_early_det u_debouncer_early_det_0 (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_sw           (i_sw[0]),
        .o_sw_debounced (w_sw_db[0])
    );

    debouncer_early_det u_debouncer_early_det_1 (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_sw           (i_sw[1]),
        .o_sw_debounced (w_sw_db[1])
    );

    parking_lot_occupancy_counter u_parking_lot_occupancy_counter (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_a         (w_sw_db[0]),
        .i_b         (w_sw_db[1]),
        .o_car_enter (w_car_enter),
        .o_car_exit  (w_car_exit)
    );

    countreg u_countreg (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_inc   (w_car_enter),
        .i_dec   (w_car_exit),
        .o_count (o_occupancy_count)
    );

    // one decoder per nibble, dp always off
    for (genvar d = 0; d < 4; d++) begin : g_digit
        hex_to_sseg u_hex_to_sseg (
            .i_hex    (o_occupancy_count[4*d +: 4]),
            .i_dp     (1'b0),
            .o_sseg_n (w_map_n[d])
        );
    end

    led_4_1_mux u_led_4_1_mux (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_in_n   (w_map_n),
        .o_ldsel  (o_ldsel),
        .o_sseg_n (o_sseg_n)
    );

endmodule

/* testbench/tb_parking_top.sv */
`timescale 1ns/100ps

`include "parking_params.svh"

module tb_parking_top;

    localparam int LEVEL_MAX      = `DB_LOCK_CYCLES + 10;   // longest hold of one sensor level
    localparam int PASS_MAX       = 6 * LEVEL_MAX;          // aborted pass at depth 3
    localparam int N_RANDOM       = 60;
    localparam int N_PASSES       = 2 + (`LOT_CAPACITY + 2) + N_RANDOM;
    localparam int SCAN_CYCLES    = 3 * 4 * `REFRESH_CYCLES;
    localparam int TIMEOUT_CYCLES = 2 * (N_PASSES * PASS_MAX + 3 * SCAN_CYCLES) + 16;

    logic                i_clk;
    logic                i_reset;
    logic [1:0]          i_sw;
    parking_pkg::count_t o_occupancy_count;
    parking_pkg::sseg_t  o_sseg_n;
    logic [3:0]          o_ldsel;

    parking_pkg::count_t model_count;
    logic [31:0]         rng_state = 32'hca6f_2beb;
    string               test_name;
    int                  n_checks;
    int                  n_errors;
    int                  cycles;
    bit                  pass_entry;
    bit                  pass_complete;

    parking_top i_dut (
        .i_clk             (i_clk),
        .i_reset           (i_reset),
        .i_sw              (i_sw),
        .o_occupancy_count (o_occupancy_count),
        .o_sseg_n          (o_sseg_n),
        .o_ldsel           (o_ldsel)
    );

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    function automatic int unsigned next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state[31:8];   // low lcg bits are weak
    endfunction

    // active low g..a, dp off
    function automatic parking_pkg::sseg_t seg_pattern(input parking_pkg::nibble_t nib);
        logic [6:0] seg;
        case (nib)
            4'h0:    seg = 7'b1000000;
            4'h1:    seg = 7'b1111001;
            4'h2:    seg = 7'b0100100;
            4'h3:    seg = 7'b0110000;
            4'h4:    seg = 7'b0011001;
            4'h5:    seg = 7'b0010010;
            4'h6:    seg = 7'b0000010;
            4'h7:    seg = 7'b1111000;
            4'h8:    seg = 7'b0000000;
            4'h9:    seg = 7'b0010000;
            4'ha:    seg = 7'b0001000;
            4'hb:    seg = 7'b0000011;
            4'hc:    seg = 7'b1000110;
            4'hd:    seg = 7'b0100001;
            4'he:    seg = 7'b0000110;
            default: seg = 7'b0001110;
        endcase
        return {1'b1, seg};
    endfunction

    task automatic check_count(input string name, input parking_pkg::count_t exp,
                               input parking_pkg::count_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("[FAIL] %s: expected count %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_sseg(input string name, input parking_pkg::sseg_t exp,
                              input parking_pkg::sseg_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("[FAIL] %s: expected segments %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_ldsel(input string name, input logic [3:0] exp, input logic [3:0] act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("[FAIL] %s: expected digit select %b, actual %b", name, exp, act);
        end
    endtask

    // one sensor level with optional bounce, count checked around the 3 cycle latency
    task automatic hold_level(input logic [1:0] lvl, input int delta, input bit fast);
        logic [1:0] chg;
        int         nb;
        int         blen;
        int         hold;
        chg  = lvl ^ i_sw;
        nb   = fast ? 0 : next_rand() % 4;
        blen = 1 + next_rand() % 2;
        hold = `DB_LOCK_CYCLES + 3 + (fast ? 0 : next_rand() % 8);
        for (int c = 0; c < hold; c++) begin
            if (c == 2)
                check_count(test_name, model_count, o_occupancy_count);   // not through yet
            if (c == 3) begin
                if (delta > 0 && model_count < `LOT_CAPACITY)
                    model_count = model_count + 1'b1;
                else if (delta < 0 && model_count > 0)
                    model_count = model_count - 1'b1;
                check_count(test_name, model_count, o_occupancy_count);
            end
            if (c >= 2 && (c - 2) / 4 < nb && (c - 2) % 4 < blen)
                i_sw = lvl ^ chg;   // bounce back
            else
                i_sw = lvl;
            @(negedge i_clk);
        end
    endtask

    task automatic run_pass(input bit entry, input bit complete, input bit fast);
        logic [1:0] path [0:3];
        int         depth;
        path[0] = entry ? 2'b01 : 2'b10;   // sw[0] is a, sw[1] is b
        path[1] = 2'b11;
        path[2] = entry ? 2'b10 : 2'b01;
        path[3] = 2'b00;
        if (complete) begin
            for (int j = 0; j < 4; j++)
                hold_level(path[j], (j < 3) ? 0 : (entry ? 1 : -1), fast);
        end else begin
            // go part way in, then retrace
            depth = 1 + next_rand() % 3;
            for (int j = 0; j < depth; j++)
                hold_level(path[j], 0, fast);
            for (int j = depth - 2; j >= 0; j--)
                hold_level(path[j], 0, fast);
            hold_level(2'b00, 0, fast);
        end
    endtask

    task automatic scan_display(input int n_cycles);
        int       zeros;
        int       idx;
        int       prev_idx;
        int       run_len;
        bit       first_run;
        bit [3:0] seen;
        prev_idx  = -1;
        run_len   = 0;
        first_run = 1'b1;
        seen      = '0;
        for (int c = 0; c < n_cycles; c++) begin
            @(negedge i_clk);
            zeros = 0;
            idx   = 0;
            for (int i = 0; i < 4; i++) begin
                if (!o_ldsel[i]) begin
                    zeros++;
                    idx = i;
                end
            end
            if (zeros != 1) begin
                n_errors++;
                $display("digit select does not have exactly one active digit: %b", o_ldsel);
            end else begin
                check_sseg(test_name, seg_pattern(model_count[4*idx +: 4]), o_sseg_n);
                seen[idx] = 1'b1;
                if (prev_idx < 0 || idx == prev_idx) begin
                    run_len++;
                end else begin
                    // scan order is 0,1,2,3 and wraps
                    if (idx != (prev_idx + 1) % 4) begin
                        n_errors++;
                        $display("digit select jumped from digit %0d to digit %0d",
                                 prev_idx, idx);
                    end
                    if (!first_run && run_len != `REFRESH_CYCLES) begin
                        n_errors++;
                        $display("digit %0d stayed selected for %0d cycles instead of %0d",
                                 prev_idx, run_len, `REFRESH_CYCLES);
                    end
                    first_run = 1'b0;
                    run_len   = 1;
                end
                prev_idx = idx;
            end
        end
        if (seen != 4'hf) begin
            n_errors++;
            $display("display scan never selected some of the digits, seen mask %b", seen);
        end
    endtask

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge i_clk);
            cycles++;
        end
        $display("timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        i_reset     = 1'b1;
        i_sw        = 2'b00;
        model_count = '0;
        n_checks    = 0;
        n_errors    = 0;
        repeat (16) @(posedge i_clk);
        @(negedge i_clk);
        i_reset = 1'b0;

        test_name = "reset";
        check_count(test_name, '0, o_occupancy_count);
        check_ldsel(test_name, 4'b1110, o_ldsel);
        check_sseg(test_name, 8'hff, o_sseg_n);

        test_name = "exit_at_zero";
        repeat (2) run_pass(1'b0, 1'b1, 1'b0);

        test_name = "saturate";
        repeat (`LOT_CAPACITY + 2) run_pass(1'b1, 1'b1, 1'b1);
        check_count(test_name, `LOT_CAPACITY, o_occupancy_count);
        test_name = "display_full";
        scan_display(SCAN_CYCLES);

        test_name = "random_pass";
        repeat (N_RANDOM) begin
            pass_entry    = next_rand() % 2;
            pass_complete = (next_rand() % 4) != 0;
            run_pass(pass_entry, pass_complete, 1'b0);
        end
        test_name = "display_random";
        scan_display(SCAN_CYCLES);

        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* project.f */
+incdir+hw
hw/parking_pkg.sv
hw/debouncer_early_det.sv
hw/parking_lot_occupancy_counter.sv
hw/countreg.sv
hw/hex_to_sseg.sv
hw/led_4_1_mux.sv
hw/parking_top.sv
testbench/tb_parking_top.sv
